// ==== Makefile ====
# Verilator build and run of the replay queue testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary -sv --top-module replayQueueTb -f project.f -o simv
	./obj_dir/simv | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== project.f ====
+incdir+verilog
verilog/mshrTypesPkg.sv
verilog/replayTypesPkg.sv
verilog/replayStorage.sv
verilog/replayIntervalTimer.sv
verilog/mshrWaitCheck.sv
verilog/replayFlushFilter.sv
verilog/replayQueueCtrl.sv
verilog/replayQueue.sv
verif/replayQueueTb.sv

// ==== verif/replayQueueTb.sv ====
// **********************************************************************
// Testbench of the replay queue
// Row table of records, MSHR ready changes and recovery pulses,
// a model queue of expected bundles, output checks and a timeout
// **********************************************************************

`include "replayQueue_config.svh"

module replayQueueTb;

    timeunit 1ns;
    timeprecision 1ps;

    import replayTypesPkg::*;
    import mshrTypesPkg::*;

    typedef struct {
        int test;
        int gap;
        logic [1:0] intV;
        logic [1:0] memV;
        logic [1:0] loadM;
        mshrIdT id;
        mshrVecT ready;
        bit rec;
        robIndexT fHead;
        robIndexT fTail;
        bit spaced;
    } rowT;

    typedef struct {
        logic [1:0] intValid;
        intOpT [1:0] intOps;
        logic [1:0] memValid;
        memOpT [1:0] memOps;
        bit waited;
        bit spaced;
        int recGap;
    } expT;

    logic clk;
    logic rstN;
    logic [`RQ_INT_WIDTH-1:0] intRecordValid;
    intOpT [`RQ_INT_WIDTH-1:0] intRecordData;
    logic [`RQ_MEM_WIDTH-1:0] memRecordValid;
    memOpT [`RQ_MEM_WIDTH-1:0] memRecordData;
    mshrVecT mshrReady;
    logic recoveryValid;
    robIndexT flushHead;
    robIndexT flushTail;
    logic [`RQ_INT_WIDTH-1:0] intReplayValid;
    intOpT [`RQ_INT_WIDTH-1:0] intReplayData;
    logic [`RQ_MEM_WIDTH-1:0] memReplayValid;
    memOpT [`RQ_MEM_WIDTH-1:0] memReplayData;
    logic replay;
    logic stallUpper;
    mshrVecT mshrRelease;
    logic flushedOpExist;

    rowT rows[$];
    expT model[$];
    logic [31:0] rngState = 32'h97f7993d;
    int cycles = 0;
    int limit = 0;
    int errors = 0;
    int testErrors = 0;
    int checks = 0;
    int flushRemaining = 0;
    bit recPending = 0;
    robIndexT fHeadM;
    robIndexT fTailM;
    int prevRecCycle = 0;
    int prevReplayCycle = 0;
    int readyRiseCycle = 0;
    int curTest = 1;

    replayQueue DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function logic [31:0] nextRandom();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    // Circular distance from the latched head decides membership
    function automatic bit inFlushRange(input robIndexT p);
        return robIndexT'(p - fHeadM) < robIndexT'(fTailM - fHeadM);
    endfunction

    task automatic addRow(input int test, input int gap, input logic [1:0] intV,
                          input logic [1:0] memV, input logic [1:0] loadM, input int id,
                          input logic [3:0] ready, input bit rec, input bit spaced);
        rowT r;
        r = '{test, gap, intV, memV, loadM, mshrIdT'(id), ready, rec, 6'd16, 6'd48, spaced};
        rows.push_back(r);
    endtask

    task automatic reportMismatch(input string name, input logic [127:0] got,
                                  input logic [127:0] exp);
        $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        errors++;
        testErrors++;
    endtask

    task automatic reportFailure(input string what);
        $display("error at %0t: %s", $time, what);
        errors++;
        testErrors++;
    endtask

    task automatic checkOutputs();
        expT e;
        logic [1:0] expIntV;
        logic [1:0] expMemV;
        mshrVecT expRel;
        int cnt;
        int replayGap;
        checks++;
        if (recPending) begin
            flushRemaining = model.size();
            recPending = 0;
        end
        if (flushedOpExist !== (flushRemaining != 0)) begin
            reportMismatch("flushedOpExist", flushedOpExist, flushRemaining != 0);
        end
        cnt = model.size() - ((replay === 1'b1) ? 1 : 0);
        if (stallUpper !== ((replay === 1'b1) || cnt >= 13)) begin
            reportMismatch("stallUpper", stallUpper, (replay === 1'b1) || cnt >= 13);
        end
        expRel = '0;
        if (replay === 1'b1 && model.size() == 0) begin
            reportFailure("replay seen with no recorded bundle left");
        end else if (replay === 1'b1) begin
            e = model.pop_front();
            expIntV = e.intValid;
            expMemV = e.memValid;
            if (flushRemaining > 0) begin
                for (int i = 0; i < 2; i++) begin
                    if (e.intValid[i] && inFlushRange(e.intOps[i].robPtr)) begin
                        expIntV[i] = 1'b0;
                    end
                    if (e.memValid[i] && inFlushRange(e.memOps[i].robPtr)) begin
                        expMemV[i] = 1'b0;
                        if (e.memOps[i].isLoad && e.memOps[i].hasMshr) begin
                            expRel[e.memOps[i].mshrId] = 1'b1;
                        end
                    end
                end
                flushRemaining--;
            end
            if (intReplayValid !== expIntV) begin
                reportMismatch("intReplayValid", intReplayValid, expIntV);
            end
            if (memReplayValid !== expMemV) begin
                reportMismatch("memReplayValid", memReplayValid, expMemV);
            end
            for (int i = 0; i < 2; i++) begin
                if (expIntV[i] && intReplayData[i] !== e.intOps[i]) begin
                    reportMismatch("intReplayData", intReplayData[i], e.intOps[i]);
                end
                if (expMemV[i] && memReplayData[i] !== e.memOps[i]) begin
                    reportMismatch("memReplayData", memReplayData[i], e.memOps[i]);
                end
                if (e.memValid[i] && e.memOps[i].hasMshr && !mshrReady[e.memOps[i].mshrId]) begin
                    reportFailure("load replayed while its MSHR had no data");
                end
            end
            if (e.waited && cycles - readyRiseCycle > 8) begin
                reportFailure("waiting load replayed more than 8 cycles after its MSHR was ready");
            end
            replayGap = cycles - prevReplayCycle;
            if (e.spaced && ((e.recGap <= 7) ? (replayGap != e.recGap) : (replayGap < 7))) begin
                reportMismatch("replay gap", replayGap, e.recGap);
            end
            prevReplayCycle = cycles;
        end else if (intReplayValid !== '0 || memReplayValid !== '0) begin
            reportMismatch("replay valids", {intReplayValid, memReplayValid}, 4'b0);
        end
        if (mshrRelease !== expRel) begin
            reportMismatch("mshrRelease", mshrRelease, expRel);
        end
    endtask

    task automatic tick();
        @(negedge clk);
        cycles++;
        if (cycles > limit) begin
            $display("run stopped: no progress within %0d cycles", limit);
            $display("TESTS FAILED");
            $finish;
        end
        checkOutputs();
    endtask

    task automatic finishTest();
        while (model.size() > 0) begin
            tick();
        end
        repeat (8) tick();
        $display("test %0d done, %0d errors", curTest, testErrors);
        testErrors = 0;
    endtask

    task automatic applyRow(input rowT r);
        expT e;
        logic [31:0] rnd;
        repeat (r.gap) tick();
        if ((r.ready & ~mshrReady) != '0) begin
            readyRiseCycle = cycles;
        end
        mshrReady = r.ready;
        if ((r.intV | r.memV) != '0) begin
            e.waited = 0;
            for (int i = 0; i < 2; i++) begin
                rnd = nextRandom();
                intRecordData[i] = '{robPtr: rnd[5:0], opcode: rnd[13:6], dstReg: rnd[19:14]};
                rnd = nextRandom();
                memRecordData[i] = '{robPtr: rnd[5:0], isLoad: r.loadM[i],
                                     hasMshr: r.loadM[i], mshrId: r.id, addr: rnd[21:6]};
                if (r.memV[i] && r.loadM[i] && !r.ready[r.id]) begin
                    e.waited = 1;
                end
            end
            intRecordValid = r.intV;
            memRecordValid = r.memV;
            e.intValid = r.intV;
            e.intOps = intRecordData;
            e.memValid = r.memV;
            e.memOps = memRecordData;
            e.spaced = r.spaced;
            e.recGap = cycles - prevRecCycle;
            prevRecCycle = cycles;
            model.push_back(e);
        end
        if (r.rec) begin
            recoveryValid = 1'b1;
            flushHead = r.fHead;
            flushTail = r.fTail;
            fHeadM = r.fHead;
            fTailM = r.fTail;
            recPending = 1;
        end
        tick();
        intRecordValid = '0;
        memRecordValid = '0;
        recoveryValid = 1'b0;
    endtask

    initial begin
        rstN = 1'b0;
        intRecordValid = '0;
        intRecordData = '0;
        memRecordValid = '0;
        memRecordData = '0;
        mshrReady = '1;
        recoveryValid = 1'b0;
        flushHead = '0;
        flushTail = '0;

        // Order and content
        addRow(1, 2, 2'b11, 2'b11, 2'b00, 0, 4'hf, 0, 0);
        addRow(1, 1, 2'b01, 2'b10, 2'b10, 1, 4'hf, 0, 0);
        addRow(1, 1, 2'b10, 2'b00, 2'b00, 0, 4'hf, 0, 0);
        addRow(1, 2, 2'b00, 2'b01, 2'b01, 2, 4'hf, 0, 0);
        addRow(1, 1, 2'b11, 2'b00, 2'b00, 0, 4'hf, 0, 0);
        addRow(1, 3, 2'b01, 2'b11, 2'b01, 3, 4'hf, 0, 0);
        // Spacing over record gaps from 1 to 12 cycles
        addRow(2, 5, 2'b01, 2'b00, 2'b00, 0, 4'hf, 0, 0);
        addRow(2, 0, 2'b10, 2'b01, 2'b00, 0, 4'hf, 0, 1);
        addRow(2, 1, 2'b01, 2'b00, 2'b00, 0, 4'hf, 0, 1);
        addRow(2, 2, 2'b11, 2'b10, 2'b00, 0, 4'hf, 0, 1);
        addRow(2, 4, 2'b01, 2'b01, 2'b00, 0, 4'hf, 0, 1);
        addRow(2, 6, 2'b10, 2'b00, 2'b00, 0, 4'hf, 0, 1);
        addRow(2, 11, 2'b01, 2'b11, 2'b00, 0, 4'hf, 0, 1);
        addRow(2, 0, 2'b11, 2'b00, 2'b00, 0, 4'hf, 0, 1);
        // MSHR wait on id 2
        addRow(3, 2, 2'b01, 2'b01, 2'b01, 2, 4'b1011, 0, 0);
        addRow(3, 1, 2'b10, 2'b10, 2'b00, 0, 4'b1011, 0, 0);
        addRow(3, 1, 2'b01, 2'b00, 2'b00, 0, 4'b1011, 0, 0);
        addRow(3, 6, 2'b00, 2'b00, 2'b00, 0, 4'b1111, 0, 0);
        // Recovery while the head load waits on id 0
        addRow(4, 2, 2'b11, 2'b11, 2'b11, 0, 4'b1110, 0, 0);
        addRow(4, 1, 2'b11, 2'b11, 2'b10, 2, 4'b1110, 0, 0);
        addRow(4, 1, 2'b01, 2'b11, 2'b01, 3, 4'b1110, 0, 0);
        addRow(4, 1, 2'b10, 2'b01, 2'b00, 0, 4'b1110, 0, 0);
        addRow(4, 3, 2'b00, 2'b00, 2'b00, 0, 4'b1110, 1, 0);
        addRow(4, 3, 2'b00, 2'b00, 2'b00, 0, 4'b1111, 0, 0);
        // Fill past the stall margin behind a blocked head
        addRow(5, 2, 2'b01, 2'b01, 2'b01, 1, 4'b1101, 0, 0);
        repeat (13) addRow(5, 1, 2'b01, 2'b10, 2'b00, 0, 4'b1101, 0, 0);
        addRow(5, 4, 2'b00, 2'b00, 2'b00, 0, 4'b1111, 0, 0);

        limit = rows.size() * 2 * 8 + 100;

        repeat (4) @(posedge clk);
        @(negedge clk);
        if (replay !== 1'b0 || stallUpper !== 1'b0 || intReplayValid !== '0 ||
                memReplayValid !== '0 || mshrRelease !== '0 || flushedOpExist !== 1'b0) begin
            reportFailure("outputs not low after reset");
        end
        rstN = 1'b1;

        foreach (rows[r]) begin
            if (rows[r].test != curTest) begin
                finishTest();
                curTest = rows[r].test;
            end
            applyRow(rows[r]);
        end
        finishTest();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/mshrTypesPkg.sv ====
// **********************************************************************
// MSHR types shared by the replay queue and the load/store unit
// MSHR index and one-bit-per-MSHR vector
// **********************************************************************

`include "replayQueue_config.svh"

package mshrTypesPkg;

    // Selects one MSHR
    typedef logic [$clog2(`RQ_MSHR_NUM)-1:0] mshrIdT;

    // One bit per MSHR, used for ready and for release
    typedef logic [`RQ_MSHR_NUM-1:0] mshrVecT;

endpackage

// ==== verilog/mshrWaitCheck.sv ====
// **********************************************************************
// MSHR checks of the memory lanes
// Head wait on loads whose MSHR has no data yet, and release
// requests for flushed loads that own an MSHR
// **********************************************************************

`include "replayQueue_config.svh"

module mshrWaitCheck (
    input  logic [`RQ_MEM_WIDTH-1:0] headValid,
    input  replayTypesPkg::memOpT [`RQ_MEM_WIDTH-1:0] headOps,
    input  mshrTypesPkg::mshrVecT mshrReady,
    input  replayTypesPkg::memOpT [`RQ_MEM_WIDTH-1:0] regOps,
    input  logic [`RQ_MEM_WIDTH-1:0] flushedLanes,
    output logic loadWait,
    output mshrTypesPkg::mshrVecT mshrRelease
);

    // Any valid head load still waiting on its MSHR blocks the pop
    always_comb begin
        loadWait = 1'b0;
        for (int i = 0; i < `RQ_MEM_WIDTH; i++) begin
            if (headValid[i] && headOps[i].isLoad && headOps[i].hasMshr &&
                    !mshrReady[headOps[i].mshrId]) begin
                loadWait = 1'b1;
            end
        end
    end

    // Suppressed lanes are already known valid, so only the owner check remains
    always_comb begin
        mshrRelease = '0;
        for (int i = 0; i < `RQ_MEM_WIDTH; i++) begin
            if (flushedLanes[i] && regOps[i].isLoad && regOps[i].hasMshr) begin
                mshrRelease[regOps[i].mshrId] = 1'b1;
            end
        end
    end

endmodule

// ==== verilog/replayFlushFilter.sv ====
// **********************************************************************
// Output register of one replay lane group
// Registers popped lanes and masks ops inside the latched flush range
// **********************************************************************

module replayFlushFilter #(
    parameter type payloadT = replayTypesPkg::intOpT,
    parameter int LANES = 2
) (
    input  logic clk,
    input  logic rstN,
    input  logic pop,
    input  logic [LANES-1:0] headValid,
    input  payloadT [LANES-1:0] headOps,
    input  logic flushActive,
    input  replayTypesPkg::robIndexT flushHeadReg,
    input  replayTypesPkg::robIndexT flushTailReg,
    output logic [LANES-1:0] replayValid,
    output payloadT [LANES-1:0] replayOps,
    output payloadT [LANES-1:0] regOps,
    output logic [LANES-1:0] flushedLanes
);

    import replayTypesPkg::*;

    logic [LANES-1:0] validReg;
    payloadT [LANES-1:0] opsReg;

    // Circular range, head inclusive and tail exclusive
    function automatic logic inRange(input robIndexT ptr, input robIndexT head,
                                     input robIndexT tail);
        if (head <= tail) begin
            return (ptr >= head) && (ptr < tail);
        end
        return (ptr >= head) || (ptr < tail);
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validReg <= '0;
        end else begin
            validReg <= pop ? headValid : '0;
        end
    end

    // Only the valid bits matter when nothing was popped
    always_ff @(posedge clk) begin
        opsReg <= headOps;
    end

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            flushedLanes[i] = validReg[i] && flushActive &&
                              inRange(opsReg[i].robPtr, flushHeadReg, flushTailReg);
            replayValid[i] = validReg[i] && !flushedLanes[i];
        end
    end

    assign replayOps = opsReg;
    assign regOps = opsReg;

endmodule

// ==== verilog/replayIntervalTimer.sv ====
// **********************************************************************
// Spacing counters of the replay queue
// Cycles since the last push and since the last pop
// **********************************************************************

`include "replayQueue_config.svh"

module replayIntervalTimer (
    input  logic clk,
    input  logic rstN,
    input  logic push,
    input  logic pop,
    output replayTypesPkg::intervalT intervalIn,
    output replayTypesPkg::intervalT intervalSincePop
);

    import replayTypesPkg::*;

    // Clear on the event, otherwise count up to the limit and hold
    function automatic intervalT stepCount(input logic clear, input intervalT cur);
        if (clear) begin
            return '0;
        end
        if (cur < intervalT'(`RQ_MAX_INTERVAL)) begin
            return cur + 1'b1;
        end
        return cur;
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            intervalIn <= '0;
            intervalSincePop <= '0;
        end else begin
            // Value at push time goes into the stored bundle
            intervalIn <= stepCount(push, intervalIn);
            intervalSincePop <= stepCount(pop, intervalSincePop);
        end
    end

endmodule

// ==== verilog/replayQueue.sv ====
// **********************************************************************
// Replay queue top level
// Controller, bundle storage, spacing timer, MSHR checks and the
// integer and memory output registers
// **********************************************************************

`include "replayQueue_config.svh"

module replayQueue (
    input  logic clk,
    input  logic rstN,
    input  logic [`RQ_INT_WIDTH-1:0] intRecordValid,
    input  replayTypesPkg::intOpT [`RQ_INT_WIDTH-1:0] intRecordData,
    input  logic [`RQ_MEM_WIDTH-1:0] memRecordValid,
    input  replayTypesPkg::memOpT [`RQ_MEM_WIDTH-1:0] memRecordData,
    input  mshrTypesPkg::mshrVecT mshrReady,
    input  logic recoveryValid,
    input  replayTypesPkg::robIndexT flushHead,
    input  replayTypesPkg::robIndexT flushTail,
    output logic [`RQ_INT_WIDTH-1:0] intReplayValid,
    output replayTypesPkg::intOpT [`RQ_INT_WIDTH-1:0] intReplayData,
    output logic [`RQ_MEM_WIDTH-1:0] memReplayValid,
    output replayTypesPkg::memOpT [`RQ_MEM_WIDTH-1:0] memReplayData,
    output logic replay,
    output logic stallUpper,
    output mshrTypesPkg::mshrVecT mshrRelease,
    output logic flushedOpExist
);

    import replayTypesPkg::*;

    logic recordAny;
    logic push;
    logic pop;
    logic full;
    logic empty;
    logic loadWait;
    logic flushActive;
    rqCountT count;
    intervalT intervalIn;
    intervalT intervalSincePop;
    robIndexT flushHeadReg;
    robIndexT flushTailReg;
    replayEntryT writeEntry;
    replayEntryT headEntry;
    memOpT [`RQ_MEM_WIDTH-1:0] memRegOps;
    logic [`RQ_MEM_WIDTH-1:0] memFlushedLanes;

    assign recordAny = |intRecordValid || |memRecordValid;

    assign writeEntry = '{
        intValid: intRecordValid,
        intOps: intRecordData,
        memValid: memRecordValid,
        memOps: memRecordData,
        interval: intervalIn
    };

    replayQueueCtrl ctrl (
        .clk(clk),
        .rstN(rstN),
        .recordAny(recordAny),
        .full(full),
        .empty(empty),
        .count(count),
        .headInterval(headEntry.interval),
        .intervalSincePop(intervalSincePop),
        .loadWait(loadWait),
        .recoveryValid(recoveryValid),
        .flushHead(flushHead),
        .flushTail(flushTail),
        .push(push),
        .pop(pop),
        .replay(replay),
        .stallUpper(stallUpper),
        .flushActive(flushActive),
        .flushHeadReg(flushHeadReg),
        .flushTailReg(flushTailReg),
        .flushedOpExist(flushedOpExist)
    );

    replayStorage storage (
        .clk(clk),
        .rstN(rstN),
        .push(push),
        .pop(pop),
        .writeEntry(writeEntry),
        .headEntry(headEntry),
        .full(full),
        .empty(empty),
        .count(count)
    );

    replayIntervalTimer timer (
        .clk(clk),
        .rstN(rstN),
        .push(push),
        .pop(pop),
        .intervalIn(intervalIn),
        .intervalSincePop(intervalSincePop)
    );

    mshrWaitCheck mshrCheck (
        .headValid(headEntry.memValid),
        .headOps(headEntry.memOps),
        .mshrReady(mshrReady),
        .regOps(memRegOps),
        .flushedLanes(memFlushedLanes),
        .loadWait(loadWait),
        .mshrRelease(mshrRelease)
    );

    // Integer lanes need neither the raw ops nor the suppressed set
    replayFlushFilter #(
        .payloadT(intOpT),
        .LANES(`RQ_INT_WIDTH)
    ) intFilter (
        .clk(clk),
        .rstN(rstN),
        .pop(pop),
        .headValid(headEntry.intValid),
        .headOps(headEntry.intOps),
        .flushActive(flushActive),
        .flushHeadReg(flushHeadReg),
        .flushTailReg(flushTailReg),
        .replayValid(intReplayValid),
        .replayOps(intReplayData),
        .regOps(),
        .flushedLanes()
    );

    replayFlushFilter #(
        .payloadT(memOpT),
        .LANES(`RQ_MEM_WIDTH)
    ) memFilter (
        .clk(clk),
        .rstN(rstN),
        .pop(pop),
        .headValid(headEntry.memValid),
        .headOps(headEntry.memOps),
        .flushActive(flushActive),
        .flushHeadReg(flushHeadReg),
        .flushTailReg(flushTailReg),
        .replayValid(memReplayValid),
        .replayOps(memReplayData),
        .regOps(memRegOps),
        .flushedLanes(memFlushedLanes)
    );

endmodule

// ==== verilog/replayQueueCtrl.sv ====
// **********************************************************************
// Replay queue control
// Push/pop decisions, the replay flag, the almost-full stall and the
// latched flush range with its countdown
// **********************************************************************

`include "replayQueue_config.svh"

module replayQueueCtrl (
    input  logic clk,
    input  logic rstN,
    input  logic recordAny,
    input  logic full,
    input  logic empty,
    input  replayTypesPkg::rqCountT count,
    input  replayTypesPkg::intervalT headInterval,
    input  replayTypesPkg::intervalT intervalSincePop,
    input  logic loadWait,
    input  logic recoveryValid,
    input  replayTypesPkg::robIndexT flushHead,
    input  replayTypesPkg::robIndexT flushTail,
    output logic push,
    output logic pop,
    output logic replay,
    output logic stallUpper,
    output logic flushActive,
    output replayTypesPkg::robIndexT flushHeadReg,
    output replayTypesPkg::robIndexT flushTailReg,
    output logic flushedOpExist
);

    import replayTypesPkg::*;

    // Bundles that may still hold flushed ops
    rqCountT flushCount;
    logic almostFull;

    // Bubbles are never recorded, so any valid lane means a push
    assign push = recordAny && !full;

    // Head keeps its recorded distance to the previous replay
    assign pop = !empty && (intervalSincePop >= headInterval) && !loadWait;

    // Room is kept for bundles already in flight when the stall rises
    assign almostFull = (count >= rqCountT'(`RQ_ENTRY_NUM - `RQ_MEM_LATENCY));
    assign stallUpper = replay || almostFull;

    // Every pop carries at least one valid lane
    always_ff @(posedge clk) begin
        if (!rstN) begin
            replay <= 1'b0;
        end else begin
            replay <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            flushCount <= '0;
        end else if (recoveryValid) begin
            flushCount <= count;
        end else if (flushActive && replay) begin
            flushCount <= flushCount - 1'b1;
        end
    end

    // Range is only looked at while the countdown runs
    always_ff @(posedge clk) begin
        if (recoveryValid) begin
            flushHeadReg <= flushHead;
            flushTailReg <= flushTail;
        end
    end

    assign flushActive = (flushCount != '0);
    assign flushedOpExist = flushActive;

endmodule

// ==== verilog/replayQueue_config.svh ====
// **********************************************************************
// Build-time sizes of the replay queue
// Lane counts, queue depth, spacing limit, stall margin, MSHR count
// and reorder-buffer index width
// **********************************************************************

`ifndef REPLAYQUEUE_CONFIG_SVH
`define REPLAYQUEUE_CONFIG_SVH

// Lanes per group
`define RQ_INT_WIDTH 2
`define RQ_MEM_WIDTH 2

// Queue depth, a power of two
`define RQ_ENTRY_NUM 16

// Saturation value of the recorded spacing
`define RQ_MAX_INTERVAL 7

// Bundles still in flight once the upper stages stall
`define RQ_MEM_LATENCY 3

`define RQ_MSHR_NUM 4

`define RQ_ROB_BITS 6

`endif

// ==== verilog/replayStorage.sv ====
// **********************************************************************
// Bundle storage of the replay queue
// Head/tail pointers, entry count and a distributed RAM with
// synchronous write and combinational head read
// **********************************************************************

`include "replayQueue_config.svh"

module replayStorage (
    input  logic clk,
    input  logic rstN,
    input  logic push,
    input  logic pop,
    input  replayTypesPkg::replayEntryT writeEntry,
    output replayTypesPkg::replayEntryT headEntry,
    output logic full,
    output logic empty,
    output replayTypesPkg::rqCountT count
);

    import replayTypesPkg::*;

    rqIndexT headPtr;
    rqIndexT tailPtr;
    replayEntryT mem [`RQ_ENTRY_NUM];

    function automatic rqIndexT nextPtr(input rqIndexT ptr);
        if (ptr == rqIndexT'(`RQ_ENTRY_NUM - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tailPtr <= nextPtr(tailPtr);
            end
            if (pop) begin
                headPtr <= nextPtr(headPtr);
            end
            // Simultaneous push and pop leave the count unchanged
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[tailPtr] <= writeEntry;
        end
    end

    assign headEntry = mem[headPtr];
    assign full = (count == rqCountT'(`RQ_ENTRY_NUM));
    assign empty = (count == '0);

endmodule

// ==== verilog/replayTypesPkg.sv ====
// **********************************************************************
// Replay queue types
// Indices, counts, recorded spacing, lane ops and the stored bundle
// **********************************************************************

`include "replayQueue_config.svh"

package replayTypesPkg;

    import mshrTypesPkg::*;

    typedef logic [`RQ_ROB_BITS-1:0] robIndexT;

    // Slot index and entry count of the queue
    typedef logic [$clog2(`RQ_ENTRY_NUM)-1:0] rqIndexT;
    typedef logic [$clog2(`RQ_ENTRY_NUM):0] rqCountT;

    // Cycles between two recorded bundles, saturating
    typedef logic [$clog2(`RQ_MAX_INTERVAL + 1)-1:0] intervalT;

    typedef struct packed {
        robIndexT robPtr;
        logic [7:0] opcode;
        logic [5:0] dstReg;
    } intOpT;

    typedef struct packed {
        robIndexT robPtr;
        logic isLoad;
        // Load already owns an MSHR from its first issue
        logic hasMshr;
        mshrIdT mshrId;
        logic [15:0] addr;
    } memOpT;

    // One recorded bundle with the spacing to its predecessor
    typedef struct packed {
        logic [`RQ_INT_WIDTH-1:0] intValid;
        intOpT [`RQ_INT_WIDTH-1:0] intOps;
        logic [`RQ_MEM_WIDTH-1:0] memValid;
        memOpT [`RQ_MEM_WIDTH-1:0] memOps;
        intervalT interval;
    } replayEntryT;

endpackage
